// ==== axi_rd_defs.svh ====
`ifndef AXI_RD_DEFS_SVH
`define AXI_RD_DEFS_SVH

// --------------------------------------------------
// AXI read channel field widths
// --------------------------------------------------
`define AXI_ID_WIDTH     4
`define AXI_ADDR_WIDTH   16
`define AXI_DATA_WIDTH   32
`define AXI_LEN_WIDTH    8
`define AXI_SIZE_WIDTH   3
`define AXI_BURST_WIDTH  2
`define AXI_RESP_WIDTH   2

// --------------------------------------------------
// Slave sizing and memory model
// --------------------------------------------------
`define MAX_BURST_LEN    8       // Beats held per slot
`define OST_DEPTH        4       // Outstanding bursts

// Fetch delay of a beat is FETCH_DELAY_MAX minus the burst ID,
// so higher IDs come back sooner and bursts interleave
`define FETCH_DELAY_MAX  24

`define ERR_ID           15      // SLVERR on the last beat of this ID

`endif

// ==== axi_rd_pkg.sv ====
`default_nettype none

`include "axi_rd_defs.svh"

package axi_rd_pkg;

    typedef logic [`AXI_ID_WIDTH-1:0]   axi_id_t;
    typedef logic [`AXI_ADDR_WIDTH-1:0] axi_addr_t;
    typedef logic [`AXI_DATA_WIDTH-1:0] axi_data_t;
    typedef logic [`AXI_LEN_WIDTH-1:0]  axi_len_t;
    typedef logic [`AXI_SIZE_WIDTH-1:0] axi_size_t;

    // AxBURST encoding
    typedef enum logic [`AXI_BURST_WIDTH-1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } burst_e;

    typedef enum logic [`AXI_RESP_WIDTH-1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_e;

    // Life cycle of one outstanding read
    typedef enum logic [1:0] {
        SLOT_FREE   = 2'b00,
        SLOT_FETCH  = 2'b01,   // Beats still arriving from memory
        SLOT_READY  = 2'b10,   // All beats fetched, draining
        SLOT_RETIRE = 2'b11    // Last beat gone, waiting for clear
    } slot_state_e;

endpackage

`default_nettype wire

// ==== rr_arbiter.sv ====
`default_nettype none

module rr_arbiter #(
    parameter int WIDTH = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [WIDTH-1:0]         req,
    input  logic                     advance,
    output logic [$clog2(WIDTH)-1:0] ptr
);

    localparam int PTR_W = $clog2(WIDTH);

    logic [PTR_W-1:0] ptr_nxt;
    logic             step;

    // Scan from the far end back toward ptr+1 so the nearest set bit
    // after the current one wins. The current bit itself is the last
    // resort, and with no request at all ptr stays where it is.
    always_comb begin : find_next
        int idx;
        ptr_nxt = ptr;
        for (int k = WIDTH; k >= 1; k--) begin
            idx = (int'(ptr) + k) % WIDTH;
            if (req[idx]) begin
                ptr_nxt = PTR_W'(idx);
            end
        end
    end

    // Pointer also hunts while its own request is low
    assign step = advance | ~req[ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (step) begin
            ptr <= ptr_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== rd_id_order.sv ====
`default_nettype none

`include "axi_rd_defs.svh"

module rd_id_order #(
    parameter int DEPTH = `OST_DEPTH
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req_fire,
    input  axi_rd_pkg::axi_id_t      req_id,
    input  logic [$clog2(DEPTH)-1:0] req_slot,
    input  logic                     resp_done,
    input  logic [$clog2(DEPTH)-1:0] resp_slot,
    output logic [DEPTH-1:0]         resp_mask
);

    import axi_rd_pkg::*;

    localparam int IDX_W = $clog2(DEPTH);

    axi_id_t          slot_id [DEPTH];     // ID held by each slot
    logic [IDX_W-1:0] age     [DEPTH];     // Older same-ID bursts still open
    logic [DEPTH-1:0] busy;
    logic [IDX_W-1:0] older_cnt;
    axi_id_t          done_id;

    assign done_id = slot_id[resp_slot];

    // --------------------------------------------------
    // Age of a new request
    // --------------------------------------------------
    // A burst that completes in the same cycle no longer counts
    always_comb begin
        older_cnt = '0;
        for (int j = 0; j < DEPTH; j++) begin
            if (busy[j] && (slot_id[j] == req_id) &&
                !(resp_done && (resp_slot == IDX_W'(j)))) begin
                older_cnt = older_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            slot_id[req_slot] <= req_id;
        end
    end

    // --------------------------------------------------
    // Per-slot age tracking
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                age[i] <= '0;
            end
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (req_fire && (req_slot == IDX_W'(i))) begin
                    busy[i] <= 1'b1;
                    age[i]  <= older_cnt;
                end else if (resp_done && (resp_slot == IDX_W'(i))) begin
                    busy[i] <= 1'b0;                   // Burst fully returned
                end else if (resp_done && busy[i] && (slot_id[i] == done_id) &&
                             (age[i] != '0)) begin
                    age[i] <= age[i] - 1'b1;           // One older burst gone
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            resp_mask[i] = busy[i] && (age[i] == '0);  // Oldest of its ID
        end
    end

endmodule

`default_nettype wire

// ==== rd_slot_engine.sv ====
`default_nettype none

`include "axi_rd_defs.svh"

module rd_slot_engine (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     alloc,
    input  axi_rd_pkg::axi_id_t      ar_id,
    input  axi_rd_pkg::axi_addr_t    ar_addr,
    input  axi_rd_pkg::axi_len_t     ar_len,
    input  axi_rd_pkg::axi_size_t    ar_size,
    input  axi_rd_pkg::burst_e       ar_burst,
    input  logic                     beat_taken,
    input  logic                     slot_release,
    output axi_rd_pkg::slot_state_e  state,
    output logic                     beat_ready,
    output axi_rd_pkg::axi_id_t      id,
    output axi_rd_pkg::axi_data_t    data,
    output axi_rd_pkg::resp_e        resp,
    output logic                     last
);

    import axi_rd_pkg::*;

    localparam int BEAT_W = $clog2(`MAX_BURST_LEN);
    localparam int CNT_W  = $clog2(`FETCH_DELAY_MAX + 1);

    // Request as accepted on AR
    axi_id_t    id_q;
    axi_addr_t  start_q;
    axi_len_t   len_q;
    axi_size_t  size_q;
    burst_e     burst_q;

    logic [CNT_W-1:0]  fetch_cnt;
    logic [CNT_W-1:0]  fetch_dly;
    logic              fetch;               // Memory returns a beat
    logic              fetch_last;
    logic [BEAT_W-1:0] wr_idx;              // Next beat to fetch
    logic [BEAT_W-1:0] rd_idx;              // Beat presented on R

    axi_addr_t cur_addr;
    axi_addr_t next_addr;
    axi_addr_t num_bytes;
    axi_addr_t wrap_mask;
    axi_addr_t wrap_base;

    axi_data_t               beat_mem [`MAX_BURST_LEN];
    logic [`MAX_BURST_LEN-1:0] beat_vld;

    always_ff @(posedge clk) begin
        if (alloc) begin
            id_q    <= ar_id;
            start_q <= ar_addr;
            len_q   <= ar_len;
            size_q  <= ar_size;
            burst_q <= ar_burst;
        end
    end

    // --------------------------------------------------
    // Slot state
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= SLOT_FREE;
        end else begin
            case (state)
                SLOT_FREE:   if (alloc) state <= SLOT_FETCH;
                SLOT_FETCH:  if (fetch && fetch_last) state <= SLOT_READY;
                SLOT_READY:  if (beat_taken && last) state <= SLOT_RETIRE;
                SLOT_RETIRE: if (slot_release) state <= SLOT_FREE;
                default:     state <= SLOT_FREE;
            endcase
        end
    end

    // --------------------------------------------------
    // Memory model, delay shrinks with the ID
    // --------------------------------------------------
    assign fetch_dly  = CNT_W'(`FETCH_DELAY_MAX) - CNT_W'(id_q);
    assign fetch      = (state == SLOT_FETCH) && (fetch_cnt == fetch_dly);
    assign fetch_last = axi_len_t'(wr_idx) == len_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_cnt <= '0;
            wr_idx    <= '0;
        end else if (alloc) begin
            fetch_cnt <= CNT_W'(1);
            wr_idx    <= '0;
        end else if (fetch) begin
            fetch_cnt <= fetch_last ? '0 : CNT_W'(1);  // Restart for next beat
            if (!fetch_last) begin
                wr_idx <= wr_idx + 1'b1;
            end
        end else if (state == SLOT_FETCH) begin
            fetch_cnt <= fetch_cnt + 1'b1;
        end
    end

    // --------------------------------------------------
    // Beat address generator
    // --------------------------------------------------
    assign num_bytes = axi_addr_t'(1) << size_q;
    assign wrap_mask = ((axi_addr_t'(len_q) + 1'b1) << size_q) - 1'b1;
    assign wrap_base = start_q & ~wrap_mask;          // Wrap window low edge

    always_comb begin
        case (burst_q)
            BURST_INCR: next_addr = (cur_addr & ~(num_bytes - 1'b1)) + num_bytes;
            BURST_WRAP: next_addr = wrap_base | ((cur_addr + num_bytes) & wrap_mask);
            default:    next_addr = cur_addr;          // FIXED repeats
        endcase
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            cur_addr <= ar_addr;
        end else if (fetch) begin
            cur_addr <= next_addr;
        end
    end

    // --------------------------------------------------
    // Beat store and read side
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (fetch) begin
            beat_mem[wr_idx] <= axi_data_t'({id_q, cur_addr});
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_vld <= '0;
            rd_idx   <= '0;
        end else if (alloc) begin
            beat_vld <= '0;
            rd_idx   <= '0;
        end else begin
            if (fetch) begin
                beat_vld[wr_idx] <= 1'b1;
            end
            if (beat_taken) begin
                rd_idx <= last ? '0 : rd_idx + 1'b1;
            end
        end
    end

    assign beat_ready = beat_vld[rd_idx] &&
                        ((state == SLOT_FETCH) || (state == SLOT_READY));
    assign id   = id_q;
    assign data = beat_mem[rd_idx];
    assign last = axi_len_t'(rd_idx) == len_q;
    assign resp = ((id_q == axi_id_t'(`ERR_ID)) && last) ? RESP_SLVERR : RESP_OKAY;

endmodule

`default_nettype wire

// ==== axi_rd_slave.sv ====
`default_nettype none

`include "axi_rd_defs.svh"

module axi_rd_slave #(
    parameter int DEPTH = `OST_DEPTH
) (
    input  logic                   clk,
    input  logic                   rst_n,

    // Read address channel
    input  axi_rd_pkg::axi_id_t    ar_id,
    input  axi_rd_pkg::axi_addr_t  ar_addr,
    input  axi_rd_pkg::axi_len_t   ar_len,
    input  axi_rd_pkg::axi_size_t  ar_size,
    input  axi_rd_pkg::burst_e     ar_burst,
    input  logic                   ar_valid,
    output logic                   ar_ready,

    // Read data channel
    output axi_rd_pkg::axi_id_t    r_id,
    output axi_rd_pkg::axi_data_t  r_data,
    output axi_rd_pkg::resp_e      r_resp,
    output logic                   r_last,
    output logic                   r_valid,
    input  logic                   r_ready
);

    import axi_rd_pkg::*;

    localparam int IDX_W = $clog2(DEPTH);

    logic ar_fire;
    logic r_fire;

    logic [IDX_W-1:0] set_ptr;              // Slot for the next AR
    logic [IDX_W-1:0] clr_ptr;              // Slot to return to FREE
    logic [IDX_W-1:0] res_ptr;              // Slot driving R

    logic [DEPTH-1:0] alloc;
    logic [DEPTH-1:0] beat_taken;
    logic [DEPTH-1:0] slot_release;
    logic [DEPTH-1:0] free_vec;
    logic [DEPTH-1:0] retire_req;
    logic [DEPTH-1:0] beat_ready;
    logic [DEPTH-1:0] resp_mask;
    logic [DEPTH-1:0] set_req;
    logic [DEPTH-1:0] res_req;

    slot_state_e      eng_state [DEPTH];
    axi_id_t          eng_id    [DEPTH];
    axi_data_t        eng_data  [DEPTH];
    resp_e            eng_resp  [DEPTH];
    logic [DEPTH-1:0] eng_last;

    assign ar_fire = ar_valid & ar_ready;
    assign r_fire  = r_valid & r_ready;

    // --------------------------------------------------
    // Slot pointers
    // --------------------------------------------------
    // A slot being cleared this cycle already counts as free, so the
    // set pointer lands on it by the time ar_ready can see it
    assign set_req = free_vec | slot_release;
    assign res_req = beat_ready & resp_mask;  // Ready and oldest of its ID

    rr_arbiter #(.WIDTH(DEPTH)) u_set_arb (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (set_req),
        .advance (ar_fire),
        .ptr     (set_ptr)
    );

    rr_arbiter #(.WIDTH(DEPTH)) u_clr_arb (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (retire_req),
        .advance (|slot_release),
        .ptr     (clr_ptr)
    );

    rr_arbiter #(.WIDTH(DEPTH)) u_res_arb (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (res_req),
        .advance (r_fire),
        .ptr     (res_ptr)
    );

    // --------------------------------------------------
    // Slot engines
    // --------------------------------------------------
    for (genvar i = 0; i < DEPTH; i++) begin : g_slot
        assign alloc[i]        = ar_fire && (set_ptr == IDX_W'(i));
        assign beat_taken[i]   = r_fire && (res_ptr == IDX_W'(i));
        assign free_vec[i]     = eng_state[i] == SLOT_FREE;
        assign retire_req[i]   = eng_state[i] == SLOT_RETIRE;
        assign slot_release[i] = retire_req[i] && (clr_ptr == IDX_W'(i));

        rd_slot_engine u_engine (
            .clk          (clk),
            .rst_n        (rst_n),
            .alloc        (alloc[i]),
            .ar_id        (ar_id),
            .ar_addr      (ar_addr),
            .ar_len       (ar_len),
            .ar_size      (ar_size),
            .ar_burst     (ar_burst),
            .beat_taken   (beat_taken[i]),
            .slot_release (slot_release[i]),
            .state        (eng_state[i]),
            .beat_ready   (beat_ready[i]),
            .id           (eng_id[i]),
            .data         (eng_data[i]),
            .resp         (eng_resp[i]),
            .last         (eng_last[i])
        );
    end

    // Per-ID ordering
    rd_id_order #(.DEPTH(DEPTH)) u_id_order (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_fire  (ar_fire),
        .req_id    (ar_id),
        .req_slot  (set_ptr),
        .resp_done (r_fire & r_last),
        .resp_slot (res_ptr),
        .resp_mask (resp_mask)
    );

    // --------------------------------------------------
    // Channel outputs
    // --------------------------------------------------
    assign ar_ready = |free_vec;            // Low only with the table full
    assign r_valid  = res_req[res_ptr];
    assign r_id     = eng_id[res_ptr];
    assign r_data   = eng_data[res_ptr];
    assign r_resp   = eng_resp[res_ptr];
    assign r_last   = r_valid && eng_last[res_ptr];

endmodule

`default_nettype wire

// ==== axi_rd_slave_sva.sv ====
`default_nettype none

module axi_rd_slave_sva (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   ar_ready,
    input  axi_rd_pkg::axi_id_t    r_id,
    input  axi_rd_pkg::axi_data_t  r_data,
    input  axi_rd_pkg::resp_e      r_resp,
    input  logic                   r_last,
    input  logic                   r_valid,
    input  logic                   r_ready
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_cnt = 0;                  // Read by the testbench at the end

    // Slot table starts empty
    a_ready_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> ar_ready)
        else begin
            fail_cnt++;
            $error("ar_ready low right after reset");
        end

    // --------------------------------------------------
    // R channel handshake rules
    // --------------------------------------------------
    a_r_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (r_valid && !r_ready) |=> (r_valid && $stable(r_id) && $stable(r_data) &&
                                   $stable(r_resp) && $stable(r_last)))
        else begin
            fail_cnt++;
            $error("R payload changed while stalled");
        end

    a_last_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        r_last |-> r_valid)
        else begin
            fail_cnt++;
            $error("r_last high without r_valid");
        end

endmodule

bind axi_rd_slave axi_rd_slave_sva u_sva (
    .clk      (clk),
    .rst_n    (rst_n),
    .ar_ready (ar_ready),
    .r_id     (r_id),
    .r_data   (r_data),
    .r_resp   (r_resp),
    .r_last   (r_last),
    .r_valid  (r_valid),
    .r_ready  (r_ready)
);

`default_nettype wire

// ==== axi_rd_slave_tb.sv ====
`default_nettype none

`include "axi_rd_defs.svh"

module axi_rd_slave_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import axi_rd_pkg::*;

    localparam int NUM_IDS = 1 << `AXI_ID_WIDTH;
    localparam int TIMEOUT = 20000;             // Cycles allowed for a drain

    typedef struct packed {
        axi_id_t   id;
        axi_addr_t addr;
        axi_len_t  len;
        axi_size_t size;
        burst_e    burst;
    } burst_rec_t;

    logic      clk;
    logic      rst_n;
    axi_id_t   ar_id;
    axi_addr_t ar_addr;
    axi_len_t  ar_len;
    axi_size_t ar_size;
    burst_e    ar_burst;
    logic      ar_valid;
    logic      ar_ready;
    axi_id_t   r_id;
    axi_data_t r_data;
    resp_e     r_resp;
    logic      r_last;
    logic      r_valid;
    logic      r_ready;

    integer     seed;
    string      test_name;
    int         to_send;                        // Bursts not yet put on AR
    int         open_bursts;                    // Accepted, last beat not seen
    bit         ar_pending;                     // Mirrors ar_valid after the edge
    bit         hold_r;
    bit         seen_full;
    int         beat_idx [NUM_IDS];
    burst_rec_t exp_q    [NUM_IDS][$];          // Expected bursts per ID, oldest first

    axi_rd_slave dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .ar_id    (ar_id),
        .ar_addr  (ar_addr),
        .ar_len   (ar_len),
        .ar_size  (ar_size),
        .ar_burst (ar_burst),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .r_id     (r_id),
        .r_data   (r_data),
        .r_resp   (r_resp),
        .r_last   (r_last),
        .r_valid  (r_valid),
        .r_ready  (r_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic axi_addr_t beat_addr(input burst_rec_t b, input int n);
        int bytes;
        int total;
        int low;
        bytes = 1 << b.size;
        total = bytes * (int'(b.len) + 1);
        low   = (int'(b.addr) / total) * total;    // Wrap window base
        case (b.burst)
            BURST_INCR: begin
                if (n == 0) begin
                    return b.addr;
                end
                return axi_addr_t'((int'(b.addr) / bytes) * bytes + n * bytes);
            end
            BURST_WRAP: return axi_addr_t'(low + (int'(b.addr) - low + n * bytes) % total);
            default:    return b.addr;
        endcase
    endfunction

    function automatic axi_data_t beat_data(input burst_rec_t b, input int n);
        return (axi_data_t'(b.id) << `AXI_ADDR_WIDTH) | axi_data_t'(beat_addr(b, n));
    endfunction

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_data(input string name, input axi_data_t exp, input axi_data_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_resp(input string name, input resp_e exp, input resp_e act);
        if (act !== exp) begin
            stop_on_error($sformatf("Mismatch %s: expected %s, actual %s",
                                    name, exp.name(), act.name()));
        end
    endtask

    task automatic check_id(input string name, input axi_id_t exp, input axi_id_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("Mismatch %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_last(input string name, input bit exp, input bit act);
        if (act !== exp) begin
            stop_on_error($sformatf("Mismatch %s: expected %0b, actual %0b", name, exp, act));
        end
    endtask

    task automatic check_beat();
        burst_rec_t b;
        axi_id_t    key;
        int         n;
        bit         is_last;
        string      name;
        resp_e      exp_resp;
        key = axi_id_t'(r_data >> `AXI_ADDR_WIDTH);   // ID field of the data word
        if ($isunknown(key)) begin
            stop_on_error("R beat arrived with an unknown ID in its data word");
        end
        if (exp_q[key].size() == 0) begin
            stop_on_error($sformatf("R beat for ID %0d arrived with no burst open", key));
        end
        b        = exp_q[key][0];
        n        = beat_idx[key];
        is_last  = (n == int'(b.len));
        name     = $sformatf("%s id %0d beat %0d", test_name, key, n);
        exp_resp = RESP_OKAY;
        if (is_last && (b.id == axi_id_t'(`ERR_ID))) begin
            exp_resp = RESP_SLVERR;
        end
        check_id(name, b.id, r_id);
        check_data(name, beat_data(b, n), r_data);
        check_resp(name, exp_resp, r_resp);
        check_last(name, is_last, r_last);
        if (is_last) begin
            void'(exp_q[key].pop_front());
            beat_idx[key] = 0;
            open_bursts--;
        end else begin
            beat_idx[key] = n + 1;
        end
    endtask

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    task automatic present_request();
        axi_size_t size;
        burst_e    burst;
        axi_len_t  len;
        axi_addr_t addr;
        size  = axi_size_t'(rand_below(3));
        burst = burst_e'(rand_below(3));
        addr  = axi_addr_t'(rand_below(65536));
        if (burst == BURST_WRAP) begin
            len  = axi_len_t'((2 << rand_below(3)) - 1);     // 2, 4 or 8 beats
            addr = addr & ~((axi_addr_t'(1) << size) - 1'b1);
        end else begin
            len = axi_len_t'(rand_below(`MAX_BURST_LEN));
        end
        ar_id      <= axi_id_t'(rand_below(NUM_IDS));
        ar_addr    <= addr;
        ar_len     <= len;
        ar_size    <= size;
        ar_burst   <= burst;
        ar_valid   <= 1'b1;
        ar_pending = 1'b1;
        to_send--;
    endtask

    task automatic step_cycle();
        burst_rec_t rec;
        @(posedge clk);
        if (ar_valid && ar_ready) begin
            rec.id    = ar_id;
            rec.addr  = ar_addr;
            rec.len   = ar_len;
            rec.size  = ar_size;
            rec.burst = ar_burst;
            exp_q[ar_id].push_back(rec);
            open_bursts++;
            ar_pending = 1'b0;
        end
        if (!ar_ready) begin
            seen_full = 1'b1;
        end
        if (r_valid && r_ready) begin
            check_beat();
        end
        if (!ar_pending) begin
            if ((to_send > 0) && (rand_below(4) != 0)) begin
                present_request();
            end else begin
                ar_valid <= 1'b0;
            end
        end
        r_ready <= hold_r ? 1'b0 : (rand_below(4) != 0);
    endtask

    task automatic run_until_idle(input int limit);
        int cycles;
        cycles = 0;
        while ((to_send > 0) || (open_bursts > 0) || ar_pending) begin
            step_cycle();
            cycles++;
            if (cycles > limit) begin
                stop_on_error($sformatf("Timeout in %s with %0d bursts still open",
                                        test_name, open_bursts));
            end
        end
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        int cycles;
        seed        = 42435;
        rst_n       = 1'b0;
        ar_id       = '0;
        ar_addr     = '0;
        ar_len      = '0;
        ar_size     = '0;
        ar_burst    = BURST_FIXED;
        ar_valid    = 1'b0;
        r_ready     = 1'b0;
        to_send     = 0;
        open_bursts = 0;
        ar_pending  = 1'b0;
        hold_r      = 1'b0;
        seen_full   = 1'b0;
        test_name   = "reset";
        for (int i = 0; i < NUM_IDS; i++) begin
            beat_idx[i] = 0;
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        if ((ar_ready !== 1'b1) || (r_valid !== 1'b0) || (r_last !== 1'b0)) begin
            stop_on_error("Channel outputs are not idle after reset");
        end

        test_name = "random traffic";           // FIXED, INCR, WRAP mixed
        to_send   = 64;
        run_until_idle(TIMEOUT);

        test_name = "backpressure";
        hold_r    = 1'b1;
        seen_full = 1'b0;
        to_send   = `OST_DEPTH + 3;
        cycles    = 0;
        while (!seen_full) begin
            step_cycle();
            cycles++;
            if (cycles > 200) begin
                stop_on_error("ar_ready never went low with the slot table full");
            end
        end
        repeat (200) step_cycle();              // Fetches land in the beat stores
        hold_r = 1'b0;
        run_until_idle(TIMEOUT);

        test_name = "idle";                     // Stray beats find no open burst
        repeat (4 * `FETCH_DELAY_MAX) step_cycle();

        if (dut0.u_sva.fail_cnt == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("%0d assertion failures", dut0.u_sva.fail_cnt);
            $display("Result: FAILED");
            $fatal(1, "Run ended with errors");
        end
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+.
axi_rd_pkg.sv
rr_arbiter.sv
rd_id_order.sv
rd_slot_engine.sv
axi_rd_slave.sv
axi_rd_slave_sva.sv
axi_rd_slave_tb.sv

// ==== Bender.yml ====
package:
  name: axi_rd_slave

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - axi_rd_pkg.sv
      - rr_arbiter.sv
      - rd_id_order.sv
      - rd_slot_engine.sv
      - axi_rd_slave.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - axi_rd_slave_sva.sv
      - axi_rd_slave_tb.sv
